//--- hdl/smc_pkg.sv
// Shared widths, access timing, AHB transfer codes and access FSM states

package smc_pkg;

  //------------------------------------------------------------
  // Bus widths
  //------------------------------------------------------------
  localparam int addr_width = 32;  // AHB and external address
  localparam int data_width = 32;  // AHB and external data
  localparam int num_lanes  = 4;   // Byte lanes on the external bus

  //------------------------------------------------------------
  // Fixed access timing, all lengths at least one cycle
  //------------------------------------------------------------
  localparam logic [1:0] csle_cycles = 2'd1;  // CS lead before strobe
  localparam logic [7:0] ws_cycles   = 8'd2;  // Strobe held this many extra cycles
  localparam logic [1:0] cste_cycles = 2'd1;  // Bus float after strobe

  // Data-phase cycles with hready low
  localparam int access_cycles = csle_cycles + ws_cycles + 1 + cste_cycles;

  //------------------------------------------------------------
  // AHB codes
  //------------------------------------------------------------
  typedef enum logic [1:0] {
    trans_idle   = 2'b00,
    trans_busy   = 2'b01,
    trans_nonseq = 2'b10,
    trans_seq    = 2'b11
  } htrans_t;

  typedef enum logic [2:0] {
    size_byte = 3'b000,
    size_half = 3'b001,
    size_word = 3'b010
  } hsize_t;

  // Access sequencer states
  typedef enum logic [1:0] {
    st_idle,    // No access
    st_lead,    // CS low, strobes not yet
    st_strobe,  // Read or write strobe low
    st_trail    // CS low, bus floating
  } smc_state_t;

endpackage

//--- hdl/smc_ahb_if.sv
// AHB-Lite slave front end: transfer qualify, hready stretch, read data return

`timescale 1ns/1ps

module smc_ahb_if import smc_pkg::*; (
  input  logic                  hclk,
  input  logic                  rst,
  // AHB slave side
  input  logic [addr_width-1:0] haddr,
  input  htrans_t               htrans,
  input  logic                  hsel,
  input  logic                  hwrite,
  input  hsize_t                hsize,
  input  logic [data_width-1:0] hwdata,
  input  logic                  hready,      // Muxed bus ready
  // External read data and sequencer status
  input  logic [data_width-1:0] data_smc,
  input  logic                  latch_data,  // Last strobe cycle
  input  logic                  smc_done,    // Last trail cycle
  // Back to the master
  output logic                  smc_valid,
  output logic                  smc_hready,
  output logic [data_width-1:0] smc_hrdata,
  // To the sequencer and output stages
  output logic                  new_access,
  output logic [addr_width-1:0] addr,
  output hsize_t                xfer_size,
  output logic                  n_read,      // Low for a read
  output logic [data_width-1:0] write_data
);

  logic                  accept;     // Valid transfer in this address phase
  logic                  stretch;    // Data phase in progress
  logic [data_width-1:0] wdata_q;    // hwdata held for the rest of the access

  //------------------------------------------------------------
  // Address phase
  //------------------------------------------------------------
  // Only NONSEQ and SEQ move data, IDLE and BUSY are ignored
  assign accept = hsel && hready &&
                  ((htrans == trans_nonseq) || (htrans == trans_seq));

  assign smc_valid = accept;  // Address acknowledge, same cycle

  // Control state
  always_ff @(posedge hclk) begin
    if (rst) begin
      new_access <= 1'b0;
      stretch    <= 1'b0;
      n_read     <= 1'b1;
    end else begin
      new_access <= accept;  // Pulse in first data-phase cycle
      if (accept) begin
        stretch <= 1'b1;
        n_read  <= hwrite;   // Write keeps n_read high
      end else if (smc_done) begin
        stretch <= 1'b0;
      end
    end
  end

  // Address and size held until the next accepted transfer
  always_ff @(posedge hclk) begin
    if (accept) begin
      addr      <= haddr;
      xfer_size <= hsize;
    end
  end

  //------------------------------------------------------------
  // Data phase
  //------------------------------------------------------------
  // hwdata is only valid in the first data-phase cycle
  always_ff @(posedge hclk) begin
    if (new_access) begin
      wdata_q <= hwdata;
    end
  end

  // Pass straight through while new_access, held copy afterwards
  assign write_data = new_access ? hwdata : wdata_q;

  // Read data sampled at the end of the strobe
  always_ff @(posedge hclk) begin
    if (latch_data && !n_read) begin
      smc_hrdata <= data_smc;
    end
  end

  // Low for the whole access, completes in the trail cycle
  assign smc_hready = !stretch || smc_done;

endmodule

//--- hdl/smc_access_fsm.sv
// Access sequencer FSM with a shared down-counter for lead, strobe and trail

`timescale 1ns/1ps

module smc_access_fsm import smc_pkg::*; (
  input  logic       hclk,
  input  logic       rst,
  input  logic       new_access,      // From AHB front end
  output smc_state_t smc_state,       // Registered current state
  output smc_state_t smc_next_state,  // Registered by output stages
  output logic       smc_done,        // Last cycle of the access
  output logic       latch_data       // Read sample point
);

  logic [7:0] cnt;    // Cycles left in current state minus one
  logic [7:0] cnt_d;  // Counter next value
  logic       cnt_zero;

  assign cnt_zero = (cnt == 8'd0);

  //------------------------------------------------------------
  // Next state and counter reload
  //------------------------------------------------------------
  always_comb begin
    smc_next_state = smc_state;
    cnt_d          = cnt;
    case (smc_state)
      st_idle: begin
        if (new_access) begin
          smc_next_state = st_lead;
          cnt_d          = {6'd0, csle_cycles} - 8'd1;  // Lead length
        end
      end
      st_lead: begin
        if (cnt_zero) begin
          smc_next_state = st_strobe;
          cnt_d          = ws_cycles;  // One cycle plus the wait states
        end else begin
          cnt_d = cnt - 8'd1;
        end
      end
      st_strobe: begin
        if (cnt_zero) begin
          smc_next_state = st_trail;
          cnt_d          = {6'd0, cste_cycles} - 8'd1;  // Bus float
        end else begin
          cnt_d = cnt - 8'd1;
        end
      end
      st_trail: begin
        if (cnt_zero) begin
          smc_next_state = st_idle;
        end else begin
          cnt_d = cnt - 8'd1;
        end
      end
      default: begin
        smc_next_state = st_idle;  // Unused encoding
      end
    endcase
  end

  //------------------------------------------------------------
  // State and counter registers
  //------------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (rst) begin
      smc_state <= st_idle;
      cnt       <= 8'd0;
    end else begin
      smc_state <= smc_next_state;
      cnt       <= cnt_d;
    end
  end

  // Status decodes
  assign smc_done   = (smc_state == st_trail) && cnt_zero;   // AHB completes here
  assign latch_data = (smc_state == st_strobe) && cnt_zero;  // Data settled at strobe end

endmodule

//--- hdl/smc_strobe_gen.sv
// External bus strobes: chip select, read, write, write lanes, output enable, busy

`timescale 1ns/1ps

module smc_strobe_gen import smc_pkg::*; (
  input  logic                 hclk,
  input  logic                 rst,
  input  smc_state_t           smc_next_state,
  input  logic                 n_read,        // Stored direction, low for read
  input  logic [num_lanes-1:0] lane_en,       // Active lanes from address stage
  output logic                 smc_n_cs,
  output logic                 smc_n_rd,
  output logic                 smc_n_wr,
  output logic [num_lanes-1:0] smc_n_we,
  output logic                 smc_n_ext_oe,  // Write data driver enable
  output logic                 smc_busy
);

  logic in_access;  // Any state but idle next cycle
  logic in_strobe;  // Strobe window next cycle
  logic rd_d;
  logic wr_d;

  //------------------------------------------------------------
  // Decode from next state
  //------------------------------------------------------------
  assign in_access = (smc_next_state != st_idle);
  assign in_strobe = (smc_next_state == st_strobe);

  assign rd_d = in_strobe && !n_read;
  assign wr_d = in_strobe && n_read;

  //------------------------------------------------------------
  // Output registers, line up with smc_state
  //------------------------------------------------------------
  always_ff @(posedge hclk) begin
    if (rst) begin
      smc_n_cs     <= 1'b1;
      smc_n_rd     <= 1'b1;
      smc_n_wr     <= 1'b1;
      smc_n_we     <= '1;
      smc_n_ext_oe <= 1'b1;
      smc_busy     <= 1'b0;
    end else begin
      smc_n_cs     <= !in_access;             // Lead, strobe and trail
      smc_n_rd     <= !rd_d;
      smc_n_wr     <= !wr_d;
      smc_n_we     <= ~({num_lanes{wr_d}} & lane_en);  // Only enabled lanes
      smc_n_ext_oe <= !(in_access && n_read);  // Drive bus for whole write access
      smc_busy     <= in_access;               // Tracks chip select
    end
  end

endmodule

//--- hdl/smc_addr_gen.sv
// External address, byte enable decode and write data registers

`timescale 1ns/1ps

module smc_addr_gen import smc_pkg::*; (
  input  logic                  hclk,
  input  logic                  rst,
  input  logic                  new_access,
  input  logic [addr_width-1:0] addr,
  input  hsize_t                xfer_size,
  input  logic [data_width-1:0] write_data,
  output logic [addr_width-1:0] smc_addr,
  output logic [num_lanes-1:0]  smc_n_be,  // Active low
  output logic [data_width-1:0] smc_data,
  output logic [num_lanes-1:0]  lane_en    // Active high, to strobe stage
);

  logic [num_lanes-1:0] be_dec;  // Lanes touched by this transfer

  //------------------------------------------------------------
  // Lane decode from size and low address bits
  //------------------------------------------------------------
  always_comb begin
    case (xfer_size)
      size_byte: be_dec = {{(num_lanes-1){1'b0}}, 1'b1} << addr[1:0];
      size_half: be_dec = addr[1] ? 4'b1100 : 4'b0011;
      default:   be_dec = '1;  // Word
    endcase
  end

  // Lane enables held for the access
  always_ff @(posedge hclk) begin
    if (rst) begin
      smc_n_be <= '1;
      lane_en  <= '0;
    end else if (new_access) begin
      smc_n_be <= ~be_dec;
      lane_en  <= be_dec;
    end
  end

  // Address and write data
  always_ff @(posedge hclk) begin
    if (new_access) begin
      smc_addr <= addr;
      smc_data <= write_data;  // Full word, lanes picked by smc_n_we
    end
  end

endmodule

//--- hdl/smc_lite.sv
// Static memory controller top: AHB front end, access FSM, strobe and address stages

`timescale 1ns/1ps

module smc_lite import smc_pkg::*; (
  input  logic                  hclk,
  input  logic                  rst,
  // AHB-Lite slave
  input  logic [addr_width-1:0] haddr,
  input  htrans_t               htrans,
  input  logic                  hsel,
  input  logic                  hwrite,
  input  hsize_t                hsize,
  input  logic [data_width-1:0] hwdata,
  input  logic                  hready,
  output logic [data_width-1:0] smc_hrdata,
  output logic                  smc_hready,
  output logic                  smc_valid,
  // External SRAM bus
  input  logic [data_width-1:0] data_smc,
  output logic [addr_width-1:0] smc_addr,
  output logic [data_width-1:0] smc_data,
  output logic [num_lanes-1:0]  smc_n_be,
  output logic                  smc_n_cs,
  output logic                  smc_n_wr,
  output logic [num_lanes-1:0]  smc_n_we,
  output logic                  smc_n_rd,
  output logic                  smc_n_ext_oe,
  output logic                  smc_busy
);

  logic                  new_access;
  logic [addr_width-1:0] addr;
  hsize_t                xfer_size;
  logic                  n_read;
  logic [data_width-1:0] write_data;
  smc_state_t            smc_state;
  smc_state_t            smc_next_state;
  logic                  smc_done;
  logic                  latch_data;
  logic [num_lanes-1:0]  lane_en;

  smc_ahb_if i_ahb_if (
    .hclk, .rst, .haddr, .htrans, .hsel, .hwrite, .hsize, .hwdata, .hready,
    .data_smc, .latch_data, .smc_done,
    .smc_valid, .smc_hready, .smc_hrdata,
    .new_access, .addr, .xfer_size, .n_read, .write_data
  );

  smc_access_fsm i_access_fsm (
    .hclk, .rst, .new_access,
    .smc_state, .smc_next_state, .smc_done, .latch_data
  );

  // Strobe and address stages run side by side off the FSM
  smc_strobe_gen i_strobe_gen (
    .hclk, .rst, .smc_next_state, .n_read, .lane_en,
    .smc_n_cs, .smc_n_rd, .smc_n_wr, .smc_n_we, .smc_n_ext_oe, .smc_busy
  );

  smc_addr_gen i_addr_gen (
    .hclk, .rst, .new_access, .addr, .xfer_size, .write_data,
    .smc_addr, .smc_n_be, .smc_data, .lane_en
  );

endmodule

//--- verif/smc_sram_model.sv
// Behavioral byte-laned SRAM on the external strobes, with a preset fill pattern

`timescale 1ns/1ps

module smc_sram_model (
  input  logic        hclk,
  input  logic [31:0] smc_addr,
  input  logic [31:0] smc_data,   // Write data from the controller
  input  logic        smc_n_cs,
  input  logic        smc_n_rd,
  input  logic        smc_n_wr,
  input  logic [3:0]  smc_n_we,
  output logic [31:0] data_smc    // Read data to the controller
);

  logic [31:0] mem [0:1023];  // 4 KB, word addressed
  logic [9:0]  idx;

  assign idx = smc_addr[11:2];

  // Fill pattern built from every bit of the word index
  initial begin
    for (int i = 0; i < 1024; i++) begin
      mem[i] = 32'h5a00_0000 ^ (i * 32'h0001_0003) ^ {i[9:0], 22'h0};
    end
  end

  // Read data only while selected and read strobe low
  assign data_smc = (!smc_n_cs && !smc_n_rd) ? mem[idx] : 32'h0;

  //------------------------------------------------------------
  // Write, lane by lane
  //------------------------------------------------------------
  always @(posedge hclk) begin
    if (!smc_n_cs && !smc_n_wr) begin
      for (int l = 0; l < 4; l++) begin
        if (!smc_n_we[l]) begin
          mem[idx][8*l +: 8] <= smc_data[8*l +: 8];  // Only enabled lanes
        end
      end
    end
  end

endmodule

//--- verif/smc_lite_props.sv
// Concurrent assertions on external strobe ordering bound to the controller top

`timescale 1ns/1ps

module smc_lite_props (
  input logic       hclk,
  input logic       rst,
  input logic       smc_n_cs,
  input logic       smc_n_rd,
  input logic       smc_n_wr,
  input logic [3:0] smc_n_we,
  input logic       smc_busy
);

  int fails = 0;  // Assertion failures so far

  // Strobes only inside chip select
  a_strobe_in_cs: assert property (@(posedge hclk) disable iff (rst)
    (!smc_n_rd || !smc_n_wr) |-> !smc_n_cs)
    else begin
      $error("read or write strobe low without chip select");
      fails++;
    end

  a_rd_wr_excl: assert property (@(posedge hclk) disable iff (rst)
    !(!smc_n_rd && !smc_n_wr))
    else begin
      $error("read and write strobes low together");
      fails++;
    end

  // Lane strobes gated by the write strobe
  a_we_in_wr: assert property (@(posedge hclk) disable iff (rst)
    (smc_n_we != 4'hf) |-> !smc_n_wr)
    else begin
      $error("write lane low without write strobe");
      fails++;
    end

  a_cs_busy: assert property (@(posedge hclk) disable iff (rst)
    !smc_n_cs |-> smc_busy)
    else begin
      $error("chip select low while not busy");
      fails++;
    end

endmodule

bind smc_lite smc_lite_props u_props (
  .hclk, .rst, .smc_n_cs, .smc_n_rd, .smc_n_wr, .smc_n_we, .smc_busy
);

//--- verif/tb_smc_lite.sv
// Testbench for the static memory controller with clock, reset, AHB tasks and directed tests

`timescale 1ns/1ps

module tb_smc_lite import smc_pkg::*; ();

  localparam int clk_period    = 40;
  localparam int num_transfers = 60;  // Upper bound over all tests
  localparam int limit_ns = num_transfers * (access_cycles + 2) * clk_period
                            + 10 * clk_period + 4000;

  logic        hclk;
  logic        rst;
  logic [31:0] haddr;
  htrans_t     htrans;
  logic        hsel;
  logic        hwrite;
  hsize_t      hsize;
  logic [31:0] hwdata;
  wire         hready;  // Ready loops back from the single slave
  logic [31:0] smc_hrdata;
  logic        smc_hready;
  logic        smc_valid;
  logic [31:0] data_smc;
  logic [31:0] smc_addr;
  logic [31:0] smc_data;
  logic [3:0]  smc_n_be;
  logic        smc_n_cs;
  logic        smc_n_wr;
  logic [3:0]  smc_n_we;
  logic        smc_n_rd;
  logic        smc_n_ext_oe;
  logic        smc_busy;

  int err_cnt;      // Errors in the running test
  int tests_ok;
  int tests_bad;
  int valid_cnt;    // Accepted address phases
  // Per-access bus observations
  int cs_low, stb_low, oe_low, cs_first, stb_first;
  logic [3:0] be_seen;

  assign hready = smc_hready;

  smc_lite UUT (.*);

  smc_sram_model i_sram (
    .hclk, .smc_addr, .smc_data, .smc_n_cs, .smc_n_rd, .smc_n_wr, .smc_n_we, .data_smc
  );

  initial begin
    hclk = 1'b0;
    forever #(clk_period / 2) hclk = ~hclk;
  end

  always @(posedge hclk) begin
    if (!rst && smc_valid) valid_cnt++;
  end

  // Watchdog
  initial begin
    #(limit_ns);
    $display("timeout: run did not finish in time");
    $display("tests failed");
    $finish;
  end

  //------------------------------------------------------------
  // Helpers
  //------------------------------------------------------------
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic drive_addr(input logic wr, input logic [31:0] a, input hsize_t sz);
    hsel   = 1'b1;
    htrans = trans_nonseq;
    hwrite = wr;
    haddr  = a;
    hsize  = sz;
  endtask

  task automatic drive_idle();
    hsel   = 1'b0;
    htrans = trans_idle;
  endtask

  // Waits for completion and records strobe activity
  task automatic wait_ready(output int low, output logic [31:0] rdata);
    int k;
    k = 0;
    low = 0;
    cs_low = 0;
    stb_low = 0;
    oe_low = 0;
    cs_first = -1;
    stb_first = -1;
    do begin
      @(posedge hclk);
      k++;
      if (!smc_n_cs) begin
        cs_low++;
        be_seen = smc_n_be;
        if (cs_first < 0) cs_first = k;
      end
      if (!smc_n_rd || !smc_n_wr) begin
        stb_low++;
        if (stb_first < 0) stb_first = k;
      end
      if (!smc_n_ext_oe) oe_low++;
      if (!smc_hready) low++;
    end while (!smc_hready && k < 50);
    rdata = smc_hrdata;
    assert (k < 50) else begin
      $error("smc_hready stayed low, transfer never completed");
      err_cnt++;
    end
  endtask

  task automatic ahb_write(input logic [31:0] a, input hsize_t sz, input logic [31:0] d);
    int          low;
    logic [31:0] unused;
    @(negedge hclk);
    drive_addr(1'b1, a, sz);
    @(negedge hclk);
    hwdata = d;  // Data phase
    drive_idle();
    wait_ready(low, unused);
    check_val("stretch_write", low, access_cycles);
  endtask

  task automatic ahb_read(input logic [31:0] a, output logic [31:0] rdata);
    int low;
    @(negedge hclk);
    drive_addr(1'b0, a, size_word);
    @(negedge hclk);
    drive_idle();
    wait_ready(low, rdata);
    check_val("stretch_read", low, access_cycles);
  endtask

  // Active-low lanes for a size and offset
  function automatic logic [3:0] n_be_for(input hsize_t sz, input logic [1:0] off);
    case (sz)
      size_byte: return ~(4'b0001 << off);
      size_half: return off[1] ? 4'b0011 : 4'b1100;
      default:   return 4'b0000;
    endcase
  endfunction

  function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] nw,
                                        input logic [3:0] n_be);
    logic [31:0] r;
    r = old;
    for (int l = 0; l < 4; l++) begin
      if (!n_be[l]) r[8*l +: 8] = nw[8*l +: 8];
    end
    return r;
  endfunction

  task automatic report(input string name);
    $display("%-16s %0d errors", name, err_cnt);
    if (err_cnt == 0) tests_ok++;
    else tests_bad++;
  endtask

  //------------------------------------------------------------
  // Tests
  //------------------------------------------------------------
  task automatic test_reset();
    err_cnt = 0;
    @(posedge hclk);
    check_val("smc_n_cs", smc_n_cs, 1'b1);
    check_val("smc_n_rd", smc_n_rd, 1'b1);
    check_val("smc_n_wr", smc_n_wr, 1'b1);
    check_val("smc_n_we", smc_n_we, 4'hf);
    check_val("smc_n_ext_oe", smc_n_ext_oe, 1'b1);
    check_val("smc_n_be", smc_n_be, 4'hf);
    check_val("smc_busy", smc_busy, 1'b0);
    check_val("smc_hready", smc_hready, 1'b1);
    check_val("smc_valid", smc_valid, 1'b0);
    report("reset");
  endtask

  task automatic test_word();
    logic [31:0] rd;
    int          v0;
    err_cnt = 0;
    v0 = valid_cnt;
    ahb_write(32'h40, size_word, 32'hdead_beef);
    ahb_read(32'h40, rd);
    check_val("smc_hrdata", rd, 32'hdead_beef);
    check_val("valid_count", valid_cnt - v0, 2);
    report("word_rw");
  endtask

  task automatic test_lanes();
    logic [31:0] exp, rd, d;
    logic [3:0]  nbe;
    err_cnt = 0;
    exp = 32'h1122_3344;
    ahb_write(32'h80, size_word, exp);
    for (int o = 0; o < 4; o++) begin
      d   = {4{8'ha0 + 8'(o)}};  // Same byte on every lane
      nbe = n_be_for(size_byte, 2'(o));
      ahb_write(32'h80 + o, size_byte, d);
      check_val("smc_n_be", be_seen, nbe);
      exp = merge(exp, d, nbe);
    end
    for (int o = 0; o < 4; o += 2) begin
      d   = {2{16'hc5d0 + 16'(o)}};
      nbe = n_be_for(size_half, 2'(o));
      ahb_write(32'h80 + o, size_half, d);
      check_val("smc_n_be", be_seen, nbe);
      exp = merge(exp, d, nbe);
    end
    ahb_read(32'h80, rd);
    check_val("smc_hrdata", rd, exp);
    report("byte_half");
  endtask

  task automatic test_timing();
    logic [31:0] rd;
    err_cnt = 0;
    ahb_read(32'h100, rd);
    check_val("cs_low_rd", cs_low, access_cycles);
    check_val("rd_delay", stb_first - cs_first, csle_cycles);
    check_val("rd_low", stb_low, ws_cycles + 1);
    check_val("oe_low_rd", oe_low, 0);
    ahb_write(32'h104, size_word, 32'h0bad_f00d);
    check_val("cs_low_wr", cs_low, access_cycles);
    check_val("wr_delay", stb_first - cs_first, csle_cycles);
    check_val("wr_low", stb_low, ws_cycles + 1);
    check_val("oe_low_wr", oe_low, access_cycles);
    report("strobe_timing");
  endtask

  task automatic test_back2back();
    int          low1, low2, v0;
    logic [31:0] rd;
    err_cnt = 0;
    v0 = valid_cnt;
    @(negedge hclk);
    drive_addr(1'b1, 32'h200, size_word);
    @(negedge hclk);
    hwdata = 32'h600d_cafe;
    drive_addr(1'b0, 32'h200, size_word);  // Held until write completes
    wait_ready(low1, rd);
    @(negedge hclk);
    drive_idle();
    wait_ready(low2, rd);
    check_val("stretch_write", low1, access_cycles);
    check_val("stretch_read", low2, access_cycles);
    check_val("smc_hrdata", rd, 32'h600d_cafe);
    check_val("valid_count", valid_cnt - v0, 2);
    report("back_to_back");
  endtask

  task automatic test_random();
    logic [31:0] sb [int];  // Scoreboard by address
    logic [31:0] a, d, rd;
    logic [31:0] addrs [$];
    err_cnt = 0;
    for (int i = 0; i < 20; i++) begin
      a = $urandom & 32'h0000_0ffc;  // Word aligned inside the model
      d = $urandom;
      ahb_write(a, size_word, d);
      sb[a] = d;
      addrs.push_back(a);
    end
    foreach (addrs[i]) begin
      ahb_read(addrs[i], rd);
      check_val("smc_hrdata", rd, sb[addrs[i]]);
    end
    report("random");
  endtask

  //------------------------------------------------------------
  // Main sequence
  //------------------------------------------------------------
  initial begin
    void'($urandom(32'h9ce689a2));
    rst = 1'b1;
    haddr = '0;
    htrans = trans_idle;
    hsel = 1'b0;
    hwrite = 1'b0;
    hsize = size_word;
    hwdata = '0;
    tests_ok = 0;
    tests_bad = 0;
    valid_cnt = 0;
    err_cnt = 0;
    repeat (10) @(negedge hclk);
    rst = 1'b0;
    test_reset();
    test_word();
    test_lanes();
    test_timing();
    test_back2back();
    test_random();
    $display("summary: %0d passed, %0d with errors, %0d assertion failures",
             tests_ok, tests_bad, UUT.u_props.fails);
    if (tests_bad == 0 && UUT.u_props.fails == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- smc_lite.f
hdl/smc_pkg.sv
hdl/smc_ahb_if.sv
hdl/smc_access_fsm.sv
hdl/smc_strobe_gen.sv
hdl/smc_addr_gen.sv
hdl/smc_lite.sv
verif/smc_sram_model.sv
verif/smc_lite_props.sv
verif/tb_smc_lite.sv
